/* rtl/dpc_corrector.sv */
`timescale 1ns/10ps
module dpc_corrector #(
    parameter int PIX_W   = 16,
    parameter int FRAME_W = 32,  // at least 3
    parameter int FRAME_H = 32   // at least 3
) (
    input  logic                                   aclk,
    input  logic                                   aresetn,
    input  logic                                   enable,
    input  logic                                   in_valid,
    input  logic                                   in_eol,
    input  logic [PIX_W-1:0]                       in_center,
    input  logic                                   in_center_good,
    input  logic [dpc_pkg::NBR_CNT-1:0][PIX_W-1:0] in_nbr,
    input  dpc_pkg::nbr_flag_t                     in_nbr_good,
    output logic                                   out_valid,
    output logic [PIX_W-1:0]                       out_data,
    output logic                                   out_sof,
    output logic                                   out_eol,
    output logic                                   out_corrected
);
    import dpc_pkg::*;

    edge_pos_e                     col_pos, row_pos;
    logic                          pad_valid, pad_enable, pad_center_good;
    logic [PIX_W-1:0]              pad_center;
    logic [NBR_CNT-1:0][PIX_W-1:0] pad_nbr;
    nbr_flag_t                     pad_nbr_good;
    logic                          acc_valid, acc_bad, acc_enable;
    logic [PIX_W-1:0]              acc_center;
    logic [3:0]                    acc_count;
    logic [PIX_W+2:0]              acc_sum;
    logic [PIX_W-1:0]              mean;

    dpc_pos_tracker #(.FRAME_W(FRAME_W), .FRAME_H(FRAME_H)) u_pos_tracker (
        .aclk, .aresetn, .in_valid, .in_eol, .col_pos, .row_pos
    );

    // 2 cycles
    dpc_window_pad #(.PIX_W(PIX_W)) u_window_pad (
        .aclk, .aresetn, .in_valid, .enable, .in_center, .in_center_good,
        .in_nbr, .in_nbr_good, .col_pos, .row_pos,
        .pad_valid, .pad_enable, .pad_center, .pad_center_good, .pad_nbr, .pad_nbr_good
    );

    // 1 cycle
    dpc_neighbor_accum #(.PIX_W(PIX_W)) u_neighbor_accum (
        .aclk, .aresetn, .pad_valid, .pad_enable, .pad_center, .pad_center_good,
        .pad_nbr, .pad_nbr_good,
        .acc_valid, .acc_center, .acc_bad, .acc_enable, .acc_count, .acc_sum
    );

    // 4 cycles
    dpc_mean_divider #(.PIX_W(PIX_W)) u_mean_divider (
        .aclk, .aresetn, .numer(acc_sum), .denom(acc_count), .quotient(mean)
    );

    dpc_output_framer #(.PIX_W(PIX_W), .FRAME_W(FRAME_W), .FRAME_H(FRAME_H)) u_output_framer (
        .aclk, .aresetn, .acc_valid, .acc_center, .acc_bad, .acc_enable, .acc_count,
        .mean, .out_valid, .out_data, .out_sof, .out_eol, .out_corrected
    );

endmodule

/* rtl/dpc_mean_divider.sv */
`timescale 1ns/10ps
module dpc_mean_divider #(
    parameter int PIX_W = 16
) (
    input  logic             aclk,
    input  logic             aresetn,
    input  logic [PIX_W+2:0] numer,
    input  logic [3:0]       denom,
    output logic [PIX_W-1:0] quotient
);
    import dpc_pkg::*;

    localparam int NW    = PIX_W + 3;
    localparam int DW    = 4;
    localparam int STEPS = (NW + MEAN_LATENCY - 1) / MEAN_LATENCY;  // quotient bits per stage

    // index 0 is the operand input, MEAN_LATENCY the last stage
    logic [NW-1:0] work_q [MEAN_LATENCY+1];  // numerator shifts out, quotient shifts in
    logic [DW:0]   rem_q  [MEAN_LATENCY+1];
    logic [DW-1:0] den_q  [MEAN_LATENCY+1];

    assign work_q[0] = numer;
    assign rem_q[0]  = '0;
    assign den_q[0]  = denom;

    for (genvar s = 0; s < MEAN_LATENCY; s++) begin : g_stage
        logic [NW-1:0] work_n;
        logic [DW:0]   rem_n;

        always_comb begin
            work_n = work_q[s];
            rem_n  = rem_q[s];
            for (int j = 0; j < STEPS; j++) begin
                if (s * STEPS + j < NW) begin  // last stage may run short
                    rem_n  = {rem_n[DW-1:0], work_n[NW-1]};
                    work_n = {work_n[NW-2:0], 1'b0};
                    if (rem_n >= {1'b0, den_q[s]}) begin
                        rem_n     = rem_n - {1'b0, den_q[s]};
                        work_n[0] = 1'b1;
                    end
                end
            end
        end

        always_ff @(posedge aclk) begin
            work_q[s+1] <= work_n;
            rem_q[s+1]  <= rem_n;
            den_q[s+1]  <= den_q[s];
        end
    end

    // mean <= max pixel, upper bits are zero
    assign quotient = work_q[MEAN_LATENCY][PIX_W-1:0];

    a_denom_range : assert property (@(posedge aclk) disable iff (!aresetn)
        denom <= DW'(NBR_CNT));

endmodule

/* rtl/dpc_neighbor_accum.sv */
`timescale 1ns/10ps
module dpc_neighbor_accum #(
    parameter int PIX_W = 16
) (
    input  logic                                   aclk,
    input  logic                                   aresetn,
    input  logic                                   pad_valid,
    input  logic                                   pad_enable,
    input  logic [PIX_W-1:0]                       pad_center,
    input  logic                                   pad_center_good,
    input  logic [dpc_pkg::NBR_CNT-1:0][PIX_W-1:0] pad_nbr,
    input  dpc_pkg::nbr_flag_t                     pad_nbr_good,
    output logic                                   acc_valid,
    output logic [PIX_W-1:0]                       acc_center,
    output logic                                   acc_bad,
    output logic                                   acc_enable,
    output logic [3:0]                             acc_count,
    output logic [PIX_W+2:0]                       acc_sum
);
    import dpc_pkg::*;

    localparam int SUM_W = PIX_W + 3;  // room for eight full-scale pixels

    logic [3:0]       cnt_n;
    logic [SUM_W-1:0] sum_n;

    always_comb begin
        cnt_n = '0;
        sum_n = '0;
        for (int i = 0; i < NBR_CNT; i++) begin
            cnt_n = cnt_n + 4'(pad_nbr_good[i]);
            if (pad_nbr_good[i])
                sum_n = sum_n + SUM_W'(pad_nbr[i]);
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            acc_valid  <= 1'b0;
            acc_bad    <= 1'b0;
            acc_enable <= 1'b0;
            acc_count  <= '0;
        end else begin
            acc_valid  <= pad_valid;
            acc_bad    <= !pad_center_good;
            acc_enable <= pad_enable;
            acc_count  <= cnt_n;
        end
    end

    always_ff @(posedge aclk) begin
        acc_sum    <= sum_n;
        acc_center <= pad_center;
    end

endmodule

/* rtl/dpc_output_framer.sv */
`timescale 1ns/10ps
module dpc_output_framer #(
    parameter int PIX_W   = 16,
    parameter int FRAME_W = 32,
    parameter int FRAME_H = 32
) (
    input  logic             aclk,
    input  logic             aresetn,
    input  logic             acc_valid,
    input  logic [PIX_W-1:0] acc_center,
    input  logic             acc_bad,
    input  logic             acc_enable,
    input  logic [3:0]       acc_count,
    input  logic [PIX_W-1:0] mean,
    output logic             out_valid,
    output logic [PIX_W-1:0] out_data,
    output logic             out_sof,
    output logic             out_eol,
    output logic             out_corrected
);
    import dpc_pkg::*;

    logic [MEAN_LATENCY-1:0] valid_dly;
    logic [MEAN_LATENCY-1:0] corr_dly;
    logic [MEAN_LATENCY-1:0] sel_dly;    // take the mean
    logic [PIX_W-1:0]        center_dly [MEAN_LATENCY];
    logic                    corr_now;
    coord_t                  col_cnt;
    coord_t                  row_cnt;

    assign corr_now = acc_valid && acc_bad && acc_enable;

    // ====================
    // side-band delay line
    // ====================
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            valid_dly <= '0;
            corr_dly  <= '0;
            sel_dly   <= '0;
        end else begin
            valid_dly <= {valid_dly[MEAN_LATENCY-2:0], acc_valid};
            corr_dly  <= {corr_dly[MEAN_LATENCY-2:0], corr_now};
            sel_dly   <= {sel_dly[MEAN_LATENCY-2:0], corr_now && (acc_count != '0)};
        end
    end

    always_ff @(posedge aclk) begin
        center_dly[0] <= acc_center;
        for (int i = 1; i < MEAN_LATENCY; i++)
            center_dly[i] <= center_dly[i-1];
    end

    assign out_valid     = valid_dly[MEAN_LATENCY-1];
    assign out_corrected = corr_dly[MEAN_LATENCY-1];
    assign out_data      = sel_dly[MEAN_LATENCY-1] ? mean : center_dly[MEAN_LATENCY-1];

    // ====================
    // output frame marks
    // ====================
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            col_cnt <= '0;
            row_cnt <= '0;
        end else if (out_valid) begin
            if (out_eol) begin
                col_cnt <= '0;
                row_cnt <= (row_cnt == coord_t'(FRAME_H - 1)) ? '0 : row_cnt + 1'b1;
            end else begin
                col_cnt <= col_cnt + 1'b1;
            end
        end
    end

    assign out_sof = out_valid && (col_cnt == '0) && (row_cnt == '0);
    assign out_eol = out_valid && (col_cnt == coord_t'(FRAME_W - 1));

endmodule

/* rtl/dpc_pkg.sv */
package dpc_pkg;

    // ====================
    // pipeline latencies
    // ====================
    localparam int PAD_LATENCY   = 2;  // column stage + row stage
    localparam int ACC_LATENCY   = 1;
    localparam int MEAN_LATENCY  = 4;  // divider register stages
    localparam int TOTAL_LATENCY = PAD_LATENCY + ACC_LATENCY + MEAN_LATENCY;

    // ====================
    // window and coordinates
    // ====================
    localparam int NBR_CNT = 8;  // 3x3 window minus the center
    localparam int COORD_W = 10;

    typedef logic [COORD_W-1:0] coord_t;

    // neighbor order 11, 12, 13, 21, 23, 31, 32, 33; bit set means good
    typedef logic [NBR_CNT-1:0] nbr_flag_t;

    // where a coordinate sits relative to the frame border
    typedef enum logic [1:0] {
        edge_first,
        edge_inner,
        edge_last
    } edge_pos_e;

endpackage

/* rtl/dpc_pos_tracker.sv */
`timescale 1ns/10ps
module dpc_pos_tracker #(
    parameter int FRAME_W = 32,
    parameter int FRAME_H = 32
) (
    input  logic               aclk,
    input  logic               aresetn,
    input  logic               in_valid,
    input  logic               in_eol,
    output dpc_pkg::edge_pos_e col_pos,
    output dpc_pkg::edge_pos_e row_pos
);
    import dpc_pkg::*;

    coord_t col_cnt;
    coord_t row_cnt;

    function automatic edge_pos_e classify(coord_t cnt, coord_t last);
        if (cnt == '0)
            return edge_first;
        else if (cnt == last)
            return edge_last;
        return edge_inner;
    endfunction

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            col_cnt <= '0;
            row_cnt <= '0;
        end else if (in_valid) begin
            if (in_eol) begin
                col_cnt <= '0;
                // wrap at the bottom of the frame
                row_cnt <= (row_cnt == coord_t'(FRAME_H - 1)) ? '0 : row_cnt + 1'b1;
            end else begin
                col_cnt <= col_cnt + 1'b1;
            end
        end
    end

    assign col_pos = classify(col_cnt, coord_t'(FRAME_W - 1));
    assign row_pos = classify(row_cnt, coord_t'(FRAME_H - 1));

    // upstream line length must match FRAME_W
    a_eol_at_last_col : assert property (@(posedge aclk) disable iff (!aresetn)
        in_valid |-> (in_eol == (col_cnt == coord_t'(FRAME_W - 1))));

endmodule

/* rtl/dpc_window_pad.sv */
`timescale 1ns/10ps
module dpc_window_pad #(
    parameter int PIX_W = 16
) (
    input  logic                                   aclk,
    input  logic                                   aresetn,
    input  logic                                   in_valid,
    input  logic                                   enable,
    input  logic [PIX_W-1:0]                       in_center,
    input  logic                                   in_center_good,
    input  logic [dpc_pkg::NBR_CNT-1:0][PIX_W-1:0] in_nbr,
    input  dpc_pkg::nbr_flag_t                     in_nbr_good,
    input  dpc_pkg::edge_pos_e                     col_pos,
    input  dpc_pkg::edge_pos_e                     row_pos,
    output logic                                   pad_valid,
    output logic                                   pad_enable,
    output logic [PIX_W-1:0]                       pad_center,
    output logic                                   pad_center_good,
    output logic [dpc_pkg::NBR_CNT-1:0][PIX_W-1:0] pad_nbr,
    output dpc_pkg::nbr_flag_t                     pad_nbr_good
);
    import dpc_pkg::*;

    // neighbor slots in the packed window
    localparam int N11 = 0;
    localparam int N12 = 1;
    localparam int N13 = 2;
    localparam int N21 = 3;
    localparam int N23 = 4;
    localparam int N31 = 5;
    localparam int N32 = 6;
    localparam int N33 = 7;

    localparam int LEFT[3]   = '{N11, N21, N31};
    localparam int RIGHT[3]  = '{N13, N23, N33};
    localparam int TOP[3]    = '{N11, N12, N13};
    localparam int BOTTOM[3] = '{N31, N32, N33};

    logic [NBR_CNT-1:0][PIX_W-1:0] col_nbr, s1_nbr, row_nbr;
    nbr_flag_t                     col_good, s1_good, row_good;
    logic [PIX_W-1:0]              s1_center;
    logic                          s1_center_good;
    logic                          s1_valid;
    logic                          s1_enable;
    edge_pos_e                     s1_row_pos;

    // ====================
    // stage one: columns
    // ====================
    always_comb begin
        col_nbr  = in_nbr;
        col_good = in_nbr_good;
        for (int i = 0; i < 3; i++) begin
            if (col_pos == edge_first) begin
                col_nbr[LEFT[i]]  = in_nbr[RIGHT[i]];
                col_good[LEFT[i]] = in_nbr_good[RIGHT[i]];
            end else if (col_pos == edge_last) begin
                col_nbr[RIGHT[i]]  = in_nbr[LEFT[i]];
                col_good[RIGHT[i]] = in_nbr_good[LEFT[i]];
            end
        end
    end

    // ====================
    // stage two: rows
    // ====================
    always_comb begin
        row_nbr  = s1_nbr;
        row_good = s1_good;
        for (int i = 0; i < 3; i++) begin
            if (s1_row_pos == edge_first) begin  // corners end up diagonal
                row_nbr[TOP[i]]  = s1_nbr[BOTTOM[i]];
                row_good[TOP[i]] = s1_good[BOTTOM[i]];
            end else if (s1_row_pos == edge_last) begin
                row_nbr[BOTTOM[i]]  = s1_nbr[TOP[i]];
                row_good[BOTTOM[i]] = s1_good[TOP[i]];
            end
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            s1_valid   <= 1'b0;
            s1_enable  <= 1'b0;
            s1_row_pos <= edge_inner;
            pad_valid  <= 1'b0;
            pad_enable <= 1'b0;
        end else begin
            s1_valid   <= in_valid;
            s1_enable  <= enable;
            s1_row_pos <= row_pos;  // row decision one cycle late
            pad_valid  <= s1_valid;
            pad_enable <= s1_enable;
        end
    end

    always_ff @(posedge aclk) begin
        s1_nbr          <= col_nbr;
        s1_good         <= col_good;
        s1_center       <= in_center;
        s1_center_good  <= in_center_good;
        pad_nbr         <= row_nbr;
        pad_nbr_good    <= row_good;
        pad_center      <= s1_center;
        pad_center_good <= s1_center_good;
    end

endmodule

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sources.f --top-module tb_dpc_corrector -o tb_dpc_corrector

out=$(./obj_dir/tb_dpc_corrector)
echo "$out"

if echo "$out" | grep -q "TB PASSED"; then
    exit 0
fi
exit 1

/* sim/tb_dpc_corrector.sv */
`timescale 1ns/10ps
module tb_dpc_corrector;
    import dpc_pkg::*;

    localparam int PIX_W           = 16;
    localparam int FRAME_W         = 8;
    localparam int FRAME_H         = 6;
    localparam int LATENCY         = 7;  // in_valid to out_valid
    localparam int RESET_CYCLES    = 8;
    localparam int FRAME_CYCLES    = FRAME_W * FRAME_H;
    localparam int WATCHDOG_CYCLES = 4 * FRAME_CYCLES + 200;  // four frames plus slack

    logic                          aclk = 1'b0;
    logic                          aresetn;
    logic                          enable;
    logic                          in_valid;
    logic                          in_eol;
    logic [PIX_W-1:0]              in_center;
    logic                          in_center_good;
    logic [NBR_CNT-1:0][PIX_W-1:0] in_nbr;
    nbr_flag_t                     in_nbr_good;
    logic                          out_valid;
    logic [PIX_W-1:0]              out_data;
    logic                          out_sof;
    logic                          out_eol;
    logic                          out_corrected;

    // expected results in arrival order
    logic [PIX_W-1:0] exp_data_q[$];
    logic             exp_corr_q[$];
    logic             exp_sof_q[$];
    logic             exp_eol_q[$];
    int               in_cyc_q[$];  // cycle of each accepted pixel

    string cur_test        = "idle";
    int    cyc             = 0;
    int    tb_col          = 0;
    int    tb_row          = 0;
    int    sof_seen        = 0;
    int    eol_seen        = 0;
    int    mismatch_errors = 0;
    int    other_errors    = 0;

    dpc_corrector #(.PIX_W(PIX_W), .FRAME_W(FRAME_W), .FRAME_H(FRAME_H)) u_dpc_corrector (
        .aclk, .aresetn, .enable, .in_valid, .in_eol, .in_center, .in_center_good,
        .in_nbr, .in_nbr_good, .out_valid, .out_data, .out_sof, .out_eol, .out_corrected
    );

    always #10 aclk = ~aclk;

    // ====================
    // compare tasks
    // ====================
    task automatic check_pixel(string name, logic [PIX_W-1:0] expected,
                               logic [PIX_W-1:0] actual);
        if (actual !== expected) begin
            mismatch_errors++;
            $display("MISMATCH %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_flag(string name, logic expected, logic actual);
        if (actual !== expected) begin
            mismatch_errors++;
            $display("MISMATCH %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic check_latency(string name, int expected, int actual);
        if (actual != expected) begin
            mismatch_errors++;
            $display("MISMATCH %s: expected %0d cycles, actual %0d cycles",
                     name, expected, actual);
        end
    endtask

    task automatic check_count(string name, int expected, int actual);
        if (actual != expected) begin
            mismatch_errors++;
            $display("MISMATCH %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    // ====================
    // reference model
    // ====================
    // offset that points outside the frame folds back across the border
    function automatic int mirror(int pos, int last, int off);
        if (pos == 0 && off < 0)
            return 1;
        if (pos == last && off > 0)
            return -1;
        return off;
    endfunction

    function automatic int slot_of(int dr, int dc);
        int k;
        k = (dr + 1) * 3 + (dc + 1);  // row-major 3x3 with the center at 4
        return (k < 4) ? k : k - 1;
    endfunction

    task automatic queue_expected(logic en, logic [PIX_W-1:0] center, logic center_good,
                                  logic [NBR_CNT-1:0][PIX_W-1:0] nbr, nbr_flag_t good);
        int   cnt;
        int   sum;
        int   sr;
        int   sc;
        int   src;
        logic corr;
        cnt = 0;
        sum = 0;
        for (int dr = -1; dr <= 1; dr++) begin
            for (int dc = -1; dc <= 1; dc++) begin
                if (dr != 0 || dc != 0) begin
                    sr  = mirror(tb_row, FRAME_H - 1, dr);
                    sc  = mirror(tb_col, FRAME_W - 1, dc);
                    src = slot_of(sr, sc);
                    if (good[src]) begin
                        cnt++;
                        sum += int'(nbr[src]);
                    end
                end
            end
        end
        corr = en && !center_good;
        exp_data_q.push_back((corr && cnt != 0) ? PIX_W'(sum / cnt) : center);
        exp_corr_q.push_back(corr);
        exp_sof_q.push_back(tb_col == 0 && tb_row == 0);
        exp_eol_q.push_back(tb_col == FRAME_W - 1);
    endtask

    // ====================
    // stimulus
    // ====================
    task automatic send_pixel(logic en, logic center_good, logic all_bad_nbrs);
        logic [PIX_W-1:0]              center;
        logic [NBR_CNT-1:0][PIX_W-1:0] nbr;
        nbr_flag_t                     good;
        center = PIX_W'($urandom);
        for (int i = 0; i < NBR_CNT; i++)
            nbr[i] = PIX_W'($urandom);  // outside the frame this is garbage
        good = all_bad_nbrs ? '0 : NBR_CNT'($urandom);
        @(posedge aclk);
        in_valid       <= 1'b1;
        enable         <= en;
        in_eol         <= (tb_col == FRAME_W - 1);
        in_center      <= center;
        in_center_good <= center_good;
        in_nbr         <= nbr;
        in_nbr_good    <= good;
        queue_expected(en, center, center_good, nbr, good);
        if (tb_col == FRAME_W - 1) begin
            tb_col = 0;
            tb_row = (tb_row == FRAME_H - 1) ? 0 : tb_row + 1;
        end else begin
            tb_col++;
        end
    endtask

    task automatic idle_cycle();
        @(posedge aclk);
        in_valid <= 1'b0;
        in_eol   <= 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_data_q.size() != 0)
            @(negedge aclk);
        @(negedge aclk);
    endtask

    task automatic run_frame(logic en, int bad_pct, logic all_bad_nbrs, logic gaps);
        for (int p = 0; p < FRAME_CYCLES; p++) begin
            send_pixel(en, int'($urandom_range(99, 0)) >= bad_pct, all_bad_nbrs);
            if (gaps && int'($urandom_range(3, 0)) == 0)
                idle_cycle();
        end
        idle_cycle();
        wait_drain();
    endtask

    // ====================
    // directed tests
    // ====================
    task automatic test_reset();
        cur_test = "reset";
        repeat (RESET_CYCLES) begin
            @(negedge aclk);
            check_flag("reset out_valid", 1'b0, out_valid);
            check_flag("reset out_corrected", 1'b0, out_corrected);
        end
        @(posedge aclk);
        aresetn <= 1'b1;
        repeat (LATENCY) begin  // pipeline still empty
            @(negedge aclk);
            check_flag("after reset out_valid", 1'b0, out_valid);
            check_flag("after reset out_corrected", 1'b0, out_corrected);
        end
    endtask

    task automatic test_bypass();
        cur_test = "bypass";
        run_frame(1'b0, 50, 1'b0, 1'b1);
    endtask

    task automatic test_interior();
        cur_test = "interior correction";
        run_frame(1'b1, 100, 1'b0, 1'b1);
    endtask

    task automatic test_no_good();
        cur_test = "no good neighbors";
        run_frame(1'b1, 100, 1'b1, 1'b0);
    endtask

    task automatic test_border_framing();
        int sof_before;
        int eol_before;
        cur_test   = "border mirroring";
        sof_before = sof_seen;
        eol_before = eol_seen;
        run_frame(1'b1, 50, 1'b0, 1'b0);  // back to back
        check_count("border sof count", 1, sof_seen - sof_before);
        check_count("border eol count", FRAME_H, eol_seen - eol_before);
    endtask

    // output monitor sampled mid-cycle
    always @(negedge aclk) begin
        if (aresetn === 1'b1 && in_valid === 1'b1)
            in_cyc_q.push_back(cyc);
        if (out_valid === 1'b1) begin
            if (exp_data_q.size() == 0 || in_cyc_q.size() == 0) begin
                other_errors++;
                $display("%s: output pixel appeared with no input pixel pending", cur_test);
            end else begin
                check_pixel({cur_test, " data"}, exp_data_q.pop_front(), out_data);
                check_flag({cur_test, " corrected"}, exp_corr_q.pop_front(), out_corrected);
                check_flag({cur_test, " sof"}, exp_sof_q.pop_front(), out_sof);
                check_flag({cur_test, " eol"}, exp_eol_q.pop_front(), out_eol);
                check_latency({cur_test, " latency"}, LATENCY, cyc - in_cyc_q.pop_front());
            end
            if (out_sof === 1'b1)
                sof_seen++;
            if (out_eol === 1'b1)
                eol_seen++;
        end
        cyc++;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge aclk);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'h8e1e264a));
        aresetn        <= 1'b0;
        enable         <= 1'b0;
        in_valid       <= 1'b0;
        in_eol         <= 1'b0;
        in_center      <= '0;
        in_center_good <= 1'b1;
        in_nbr         <= '0;
        in_nbr_good    <= '0;
        test_reset();
        test_bypass();
        test_interior();
        test_no_good();
        test_border_framing();
        $display("errors: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
        if (mismatch_errors == 0 && other_errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

/* sources.f */
rtl/dpc_pkg.sv
rtl/dpc_pos_tracker.sv
rtl/dpc_window_pad.sv
rtl/dpc_neighbor_accum.sv
rtl/dpc_mean_divider.sv
rtl/dpc_output_framer.sv
rtl/dpc_corrector.sv
sim/tb_dpc_corrector.sv
